//--- src/jbus_cfg.svh
// jbus and Wishbone bus widths, scratch RAM depth,
// timer decode bit and bridge pipelining switch
`ifndef JBUS_CFG_SVH
`define JBUS_CFG_SVH

// word address and data sizing
`define JBUS_ADDR_WIDTH 30
`define JBUS_DATA_SIZE 2
`define JBUS_DATA_WIDTH (8 << `JBUS_DATA_SIZE)
`define JBUS_SEL_WIDTH (1 << `JBUS_DATA_SIZE)

// 256 words of scratch RAM, timer block above it
`define JBUS_RAM_AWIDTH 8
`define JBUS_DEC_BIT 8

// 1 registers the bridge, 0 passes straight through
`define JBUS_BRIDGE_PIPELINE 1

`endif

//--- src/jbus_pkg.sv
// Wishbone and jbus request/response structs,
// timer register index enum
`include "jbus_cfg.svh"

package jbus_pkg;

	// ------------------------------------------------------------
	// Wishbone slave port
	// ------------------------------------------------------------
	typedef struct packed {
		logic [`JBUS_ADDR_WIDTH-1:0] adr;
		logic [`JBUS_DATA_WIDTH-1:0] dat;
		logic                        we;
		logic [`JBUS_SEL_WIDTH-1:0]  sel;
		logic                        stb;
	} wb_req_t;

	typedef struct packed {
		logic [`JBUS_DATA_WIDTH-1:0] dat;
		logic                        ack;
	} wb_resp_t;

	// ------------------------------------------------------------
	// jbus master to slave
	// ------------------------------------------------------------
	typedef struct packed {
		logic                        en;
		logic [`JBUS_ADDR_WIDTH-1:0] addr;
		logic [`JBUS_DATA_WIDTH-1:0] wdata;
		logic                        we;
		logic [`JBUS_SEL_WIDTH-1:0]  sel;
		logic                        valid;
	} jbus_req_t;

	// rdata only meaningful in the data cycle of a read
	typedef struct packed {
		logic [`JBUS_DATA_WIDTH-1:0] rdata;
		logic                        ready;
	} jbus_resp_t;

	// timer registers, picked by the low word address bits
	typedef enum logic [1:0] {
		TIMER_CTRL    = 2'd0,
		TIMER_COUNT   = 2'd1,
		TIMER_COMPARE = 2'd2,
		TIMER_STATUS  = 2'd3
	} timer_reg_e;

endpackage

//--- src/wishbone_to_jbus.sv
// Wishbone slave to jbus master bridge, registered or pass-through
`timescale 1ns/1ps
`include "jbus_cfg.svh"

module wishbone_to_jbus #(
	parameter int PIPELINE = `JBUS_BRIDGE_PIPELINE
) (
	input  logic                 clk,
	input  logic                 reset,
	input  jbus_pkg::wb_req_t    wb_req_i,
	output jbus_pkg::wb_resp_t   wb_resp_o,
	output jbus_pkg::jbus_req_t  m_req_o,
	input  jbus_pkg::jbus_resp_t m_resp_i
);
	logic read_pend;
	logic accept;

	assign accept = m_req_o.en & m_req_o.valid & m_resp_i.ready;

	// set when a read is accepted, drops in the data cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			read_pend <= 1'b0;
		end else if (m_resp_i.ready) begin
			read_pend <= accept & ~m_req_o.we;
		end
	end

	generate
		if (PIPELINE != 0) begin : g_registered
			logic                        valid_q;
			logic [`JBUS_ADDR_WIDTH-1:0] addr_q;
			logic [`JBUS_DATA_WIDTH-1:0] wdata_q;
			logic                        we_q;
			logic [`JBUS_SEL_WIDTH-1:0]  sel_q;
			logic                        ack_q;
			logic [`JBUS_DATA_WIDTH-1:0] dat_q;

			// ------------------------------------------------------------
			// request register, frozen while the slave stalls
			// ------------------------------------------------------------
			always_ff @(posedge clk) begin
				if (reset) begin
					valid_q <= 1'b0;
				end else if (~valid_q | m_resp_i.ready) begin
					// one request per stb, nothing new until the ack is out
					valid_q <= wb_req_i.stb & ~valid_q & ~read_pend & ~ack_q;
				end
			end

			always_ff @(posedge clk) begin
				if (~valid_q | m_resp_i.ready) begin
					addr_q  <= wb_req_i.adr;
					wdata_q <= wb_req_i.dat;
					we_q    <= wb_req_i.we;
					sel_q   <= wb_req_i.sel;
				end
			end

			// read ack and data registered from the data cycle
			always_ff @(posedge clk) begin
				if (reset) begin
					ack_q <= 1'b0;
				end else begin
					ack_q <= read_pend & m_resp_i.ready;
				end
			end

			always_ff @(posedge clk) begin
				if (read_pend & m_resp_i.ready) begin
					dat_q <= m_resp_i.rdata;
				end
			end

			assign m_req_o = '{en: 1'b1, addr: addr_q, wdata: wdata_q, we: we_q,
				sel: sel_q, valid: valid_q};
			// writes ack on acceptance
			assign wb_resp_o = '{dat: dat_q,
				ack: ack_q | (valid_q & we_q & m_resp_i.ready)};
		end else begin : g_passthru
			assign m_req_o = '{en: 1'b1, addr: wb_req_i.adr, wdata: wb_req_i.dat,
				we: wb_req_i.we, sel: wb_req_i.sel, valid: wb_req_i.stb & ~read_pend};
			assign wb_resp_o = '{dat: m_resp_i.rdata,
				ack: m_resp_i.ready & (read_pend | (wb_req_i.stb & wb_req_i.we))};
		end
	endgenerate

endmodule

//--- src/jbus_ram.sv
// jbus scratch RAM, byte-writable, registered read data
`timescale 1ns/1ps
`include "jbus_cfg.svh"

module jbus_ram (
	input  logic                 clk,
	input  jbus_pkg::jbus_req_t  slv_req_i,
	output jbus_pkg::jbus_resp_t slv_resp_o
);
	localparam int DEPTH = 1 << `JBUS_RAM_AWIDTH;

	logic [`JBUS_DATA_WIDTH-1:0] mem [DEPTH];
	logic [`JBUS_RAM_AWIDTH-1:0] word_addr;
	logic [`JBUS_DATA_WIDTH-1:0] rdata_q;
	logic                        ready;
	logic                        accept;

	// never stalls
	assign ready = 1'b1;
	assign accept = slv_req_i.en & slv_req_i.valid & ready;

	// upper address bits ignored, decode is done in the router
	assign word_addr = slv_req_i.addr[`JBUS_RAM_AWIDTH-1:0];

	always_ff @(posedge clk) begin
		if (accept) begin
			if (slv_req_i.we) begin
				for (int i = 0; i < `JBUS_SEL_WIDTH; i++) begin
					if (slv_req_i.sel[i]) begin
						mem[word_addr][8*i +: 8] <= slv_req_i.wdata[8*i +: 8];
					end
				end
			end else begin
				rdata_q <= mem[word_addr];
			end
		end
	end

	assign slv_resp_o = '{rdata: rdata_q, ready: ready};

endmodule

//--- src/jbus_timer_regs.sv
// jbus timer register block
// control, free-running counter, compare and sticky match flag
`timescale 1ns/1ps
`include "jbus_cfg.svh"

module jbus_timer_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  jbus_pkg::jbus_req_t  slv_req_i,
	output jbus_pkg::jbus_resp_t slv_resp_o
);
	import jbus_pkg::*;

	timer_reg_e                  reg_sel;
	logic                        ready;
	logic                        accept;
	logic                        wr;
	logic                        hit;
	logic                        ctrl_en;
	logic [`JBUS_DATA_WIDTH-1:0] count_q;
	logic [`JBUS_DATA_WIDTH-1:0] compare_q;
	logic                        match_q;
	logic [`JBUS_DATA_WIDTH-1:0] rdata_q;

	assign ready = 1'b1;
	assign accept = slv_req_i.en & slv_req_i.valid & ready;
	assign wr = accept & slv_req_i.we;
	assign reg_sel = timer_reg_e'(slv_req_i.addr[1:0]);
	assign hit = ctrl_en & (count_q == compare_q);

	// ------------------------------------------------------------
	// register updates, sel ignored on writes
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_en   <= 1'b0;
			count_q   <= '0;
			compare_q <= '0;
			match_q   <= 1'b0;
		end else begin
			if (wr && reg_sel == TIMER_CTRL) begin
				ctrl_en <= slv_req_i.wdata[0];
			end
			// a write to the counter wins over the increment
			if (wr && reg_sel == TIMER_COUNT) begin
				count_q <= slv_req_i.wdata;
			end else if (ctrl_en) begin
				count_q <= count_q + 1'b1;
			end
			if (wr && reg_sel == TIMER_COMPARE) begin
				compare_q <= slv_req_i.wdata;
			end
			// new match beats write-1-to-clear
			if (hit) begin
				match_q <= 1'b1;
			end else if (wr && reg_sel == TIMER_STATUS && slv_req_i.wdata[0]) begin
				match_q <= 1'b0;
			end
		end
	end

	// read mux, unused bits zero
	always_ff @(posedge clk) begin
		if (accept && !slv_req_i.we) begin
			case (reg_sel)
				TIMER_CTRL:    rdata_q <= {{(`JBUS_DATA_WIDTH-1){1'b0}}, ctrl_en};
				TIMER_COUNT:   rdata_q <= count_q;
				TIMER_COMPARE: rdata_q <= compare_q;
				default:       rdata_q <= {{(`JBUS_DATA_WIDTH-1){1'b0}}, match_q};
			endcase
		end
	end

	assign slv_resp_o = '{rdata: rdata_q, ready: ready};

endmodule

//--- src/jbus_router.sv
// jbus address decode onto RAM and timer slaves
// with response combining
`timescale 1ns/1ps
`include "jbus_cfg.svh"

module jbus_router (
	input  logic                 clk,
	input  logic                 reset,
	input  jbus_pkg::jbus_req_t  m_req_i,
	output jbus_pkg::jbus_resp_t m_resp_o,
	output jbus_pkg::jbus_req_t  ram_req_o,
	output jbus_pkg::jbus_req_t  tmr_req_o,
	input  jbus_pkg::jbus_resp_t ram_resp_i,
	input  jbus_pkg::jbus_resp_t tmr_resp_i
);
	// high selects the timer block
	logic dec;
	logic rd_sel_q;
	logic rdy_sel;

	assign dec = m_req_i.addr[`JBUS_DEC_BIT];

	// fields go to both, valid only to the addressed one
	always_comb begin
		ram_req_o       = m_req_i;
		tmr_req_o       = m_req_i;
		ram_req_o.valid = m_req_i.valid & ~dec;
		tmr_req_o.valid = m_req_i.valid & dec;
	end

	// slave of the last accepted read owns the data cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_sel_q <= 1'b0;
		end else if (m_req_i.en & m_req_i.valid & m_resp_o.ready & ~m_req_i.we) begin
			rd_sel_q <= dec;
		end
	end

	// current decode while a request is up, else the pending read's slave
	assign rdy_sel = m_req_i.valid ? dec : rd_sel_q;

	assign m_resp_o.ready = rdy_sel ? tmr_resp_i.ready : ram_resp_i.ready;
	assign m_resp_o.rdata = rd_sel_q ? tmr_resp_i.rdata : ram_resp_i.rdata;

endmodule

//--- src/wb_jbus_subsystem.sv
// top level: Wishbone bridge, jbus router, scratch RAM and timer
`timescale 1ns/1ps
`include "jbus_cfg.svh"

module wb_jbus_subsystem (
	input  logic               clk,
	input  logic               reset,
	input  jbus_pkg::wb_req_t  wb_req_i,
	output jbus_pkg::wb_resp_t wb_resp_o
);
	import jbus_pkg::*;

	jbus_req_t  m_req;
	jbus_resp_t m_resp;
	jbus_req_t  ram_req;
	jbus_resp_t ram_resp;
	jbus_req_t  tmr_req;
	jbus_resp_t tmr_resp;

	wishbone_to_jbus #(
		.PIPELINE (`JBUS_BRIDGE_PIPELINE)
	) u_bridge (
		.clk       (clk),
		.reset     (reset),
		.wb_req_i  (wb_req_i),
		.wb_resp_o (wb_resp_o),
		.m_req_o   (m_req),
		.m_resp_i  (m_resp)
	);

	jbus_router u_router (
		.clk        (clk),
		.reset      (reset),
		.m_req_i    (m_req),
		.m_resp_o   (m_resp),
		.ram_req_o  (ram_req),
		.tmr_req_o  (tmr_req),
		.ram_resp_i (ram_resp),
		.tmr_resp_i (tmr_resp)
	);

	jbus_ram u_ram (
		.clk        (clk),
		.slv_req_i  (ram_req),
		.slv_resp_o (ram_resp)
	);

	jbus_timer_regs u_timer (
		.clk        (clk),
		.reset      (reset),
		.slv_req_i  (tmr_req),
		.slv_resp_o (tmr_resp)
	);

endmodule

//--- testbench/wb_jbus_props.sv
// bound assertions on the bridge Wishbone and jbus ports
`timescale 1ns/1ps

module wb_jbus_props (
	input logic                clk,
	input logic                reset,
	input jbus_pkg::wb_req_t   wb_req_i,
	input jbus_pkg::wb_resp_t  wb_resp_i,
	input jbus_pkg::jbus_req_t m_req_i,
	input logic                read_pend_i
);
	// one ack per request, the master drops stb after it
	assert property (@(posedge clk) disable iff (reset)
		wb_resp_i.ack && wb_req_i.stb |=> !(wb_resp_i.ack && wb_req_i.stb))
		else $error("ack high two cycles in a row with stb held");

	// no second request while read data is outstanding or being acked
	assert property (@(posedge clk) disable iff (reset)
		read_pend_i |-> !m_req_i.valid ##1 !m_req_i.valid)
		else $error("jbus valid raised during a pending read or its ack");

	assert property (@(posedge clk)
		$fell(reset) |-> !wb_resp_i.ack ##1 !wb_resp_i.ack)
		else $error("ack raised within two cycles of reset release");

endmodule

bind wishbone_to_jbus wb_jbus_props u_props (
	.clk         (clk),
	.reset       (reset),
	.wb_req_i    (wb_req_i),
	.wb_resp_i   (wb_resp_o),
	.m_req_i     (m_req_o),
	.read_pend_i (read_pend)
);

//--- testbench/tb_wb_jbus.sv
// trace-driven Wishbone master for the jbus subsystem
// with read data, ack and counter compare tasks
`timescale 1ns/1ps
`include "jbus_cfg.svh"

module tb_wb_jbus;
	import jbus_pkg::*;

	localparam int ACK_TIMEOUT = 50;

	logic     clk = 1'b0;
	logic     reset;
	wb_req_t  wb_req_i;
	wb_resp_t wb_resp_o;
	integer   seed;

	wb_jbus_subsystem uut (
		.clk       (clk),
		.reset     (reset),
		.wb_req_i  (wb_req_i),
		.wb_resp_o (wb_resp_o)
	);

	always #10 clk = ~clk;

	task automatic abort_sim();
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_rdata(input logic [`JBUS_ADDR_WIDTH-1:0] adr,
		input logic [`JBUS_DATA_WIDTH-1:0] got, input logic [`JBUS_DATA_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED wb_resp_o.dat at adr 0x%h: got 0x%h, expected 0x%h",
				adr, got, exp);
			abort_sim();
		end
	endtask

	task automatic check_ack_only(input logic exp, input logic got, input string what);
		if (got !== exp) begin
			$display("Wishbone ack problem: %s", what);
			abort_sim();
		end
	endtask

	task automatic expect_rise(input logic [`JBUS_ADDR_WIDTH-1:0] adr,
		input logic [`JBUS_DATA_WIDTH-1:0] first, input logic [`JBUS_DATA_WIDTH-1:0] second);
		if ($isunknown({first, second}) || second <= first) begin
			$display("CHECK FAILED wb_resp_o.dat at adr 0x%h did not rise: 0x%h then 0x%h",
				adr, first, second);
			abort_sim();
		end
	endtask

	// one Wishbone cycle, stb held until ack, then dropped for a cycle
	task automatic wb_transfer(input logic [`JBUS_ADDR_WIDTH-1:0] adr,
		input logic [`JBUS_DATA_WIDTH-1:0] dat, input logic we,
		input logic [`JBUS_SEL_WIDTH-1:0] sel, output logic [`JBUS_DATA_WIDTH-1:0] rdata);
		logic got;
		int   n;
		got = 1'b0;
		rdata = 'x;
		@(posedge clk);
		wb_req_i <= '{adr: adr, dat: dat, we: we, sel: sel, stb: 1'b1};
		for (n = 0; n < ACK_TIMEOUT && !got; n++) begin
			@(negedge clk);
			if (wb_resp_o.ack === 1'b1) begin
				got = 1'b1;
				rdata = wb_resp_o.dat;
			end
		end
		check_ack_only(1'b1, got, "no ack within 50 cycles of stb");
		@(posedge clk);
		wb_req_i.stb <= 1'b0;
		@(negedge clk);
		check_ack_only(1'b0, wb_resp_o.ack, "ack still high after stb was dropped");
	endtask

	initial begin
		int                          fd;
		int                          c;
		int                          n_ops;
		int                          gap;
		logic [8*160-1:0]            skip_line;
		logic [`JBUS_ADDR_WIDTH-1:0] adr;
		logic [`JBUS_DATA_WIDTH-1:0] dat;
		logic [`JBUS_SEL_WIDTH-1:0]  sel;
		logic [`JBUS_DATA_WIDTH-1:0] exp_val;
		logic [`JBUS_DATA_WIDTH-1:0] first;
		logic [`JBUS_DATA_WIDTH-1:0] second;

		seed = 42097;
		n_ops = 0;
		reset = 1'b1;
		wb_req_i = '0;
		fd = $fopen("testbench/wb_jbus_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file testbench/wb_jbus_trace.txt");
			abort_sim();
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				c = $fgets(skip_line, fd);
			end else if (c == "W" || c == "R" || c == "M") begin
				if ($fscanf(fd, "%h %h %h %h\n", adr, dat, sel, exp_val) != 4) begin
					$display("malformed line in the trace file after %0d transactions", n_ops);
					abort_sim();
				end
				case (c)
					"W": wb_transfer(adr, dat, 1'b1, sel, first);
					"R": begin
						wb_transfer(adr, dat, 1'b0, sel, first);
						check_rdata(adr, first, exp_val);
					end
					default: begin
						// counter must have moved between the two reads
						wb_transfer(adr, dat, 1'b0, sel, first);
						wb_transfer(adr, dat, 1'b0, sel, second);
						expect_rise(adr, first, second);
					end
				endcase
				n_ops++;
				gap = $unsigned($random(seed)) % 4;
				repeat (gap) @(posedge clk);
			end else if (c != " " && c != "\n" && c != "\r") begin
				$display("unknown operation letter in the trace file");
				abort_sim();
			end
			c = $fgetc(fd);
		end
		$fclose(fd);

		if (n_ops > 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("the trace file held no transactions");
			abort_sim();
		end
	end

endmodule

//--- project.f
+incdir+src
src/jbus_pkg.sv
src/wishbone_to_jbus.sv
src/jbus_ram.sv
src/jbus_timer_regs.sv
src/jbus_router.sv
src/wb_jbus_subsystem.sv
testbench/wb_jbus_props.sv
testbench/tb_wb_jbus.sv

//--- Bender.yml
package:
  name: wb_jbus_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/jbus_pkg.sv
      - src/wishbone_to_jbus.sv
      - src/jbus_ram.sv
      - src/jbus_timer_regs.sv
      - src/jbus_router.sv
      - src/wb_jbus_subsystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/wb_jbus_props.sv
      - testbench/tb_wb_jbus.sv

//--- testbench/wb_jbus_trace.txt
# op adr dat sel expected, all hex; W writes, R reads and compares
# M reads twice and needs the second value larger; timer at adr 100-103
W 000 DEADBEEF F 00000000
W 001 CAFEF00D F 00000000
R 000 00000000 F DEADBEEF
R 001 00000000 F CAFEF00D
W 010 11223344 F 00000000
W 010 AABBCCDD 3 00000000
R 010 00000000 F 1122CCDD
W 010 55667788 8 00000000
R 010 00000000 F 5522CCDD
W 0FF A5A5A5A5 F 00000000
W 102 00000777 F 00000000
R 0FF 00000000 F A5A5A5A5
R 102 00000000 F 00000777
R 000 00000000 F DEADBEEF
W 101 12345678 F 00000000
R 101 00000000 F 12345678
W 100 00000001 F 00000000
R 100 00000000 F 00000001
M 101 00000000 F 00000000
W 100 00000000 F 00000000
R 103 00000000 F 00000000
W 101 00000200 F 00000000
W 102 00000205 F 00000000
W 100 00000001 F 00000000
M 101 00000000 F 00000000
W 100 00000000 F 00000000
R 103 00000000 F 00000001
W 103 00000001 F 00000000
R 103 00000000 F 00000000
